// File: gfx_pkg.sv
// shared types, display timing, palette and shape table for the triangle renderer
// modules pull these in with a wildcard import in their header
package gfx_pkg;

    typedef logic signed [15:0] coord_t;    // screen coordinate
    typedef logic [3:0]         cidx_t;     // colour index
    typedef logic [3:0]         chan_t;     // colour channel
    typedef logic [11:0]        fb_addr_t;  // framebuffer address

    localparam int FB_WIDTH  = 64;
    localparam int FB_HEIGHT = 36;

    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 8;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 84

    localparam int V_ACTIVE = 36;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 4;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 44

    localparam int SHAPE_CNT = 3;

    // three vertices per shape
    localparam coord_t SHAPE_VX [0:SHAPE_CNT-1][0:2] = '{'{12, 56, 32}, '{14, 44, 34}, '{4, 12, 19}};
    localparam coord_t SHAPE_VY [0:SHAPE_CNT-1][0:2] = '{'{4, 16, 32}, '{32, 18, 2}, '{7, 30, 19}};
    localparam cidx_t SHAPE_CIDX [0:SHAPE_CNT-1] = '{4'h9, 4'hC, 4'h2};  // orange, blue, purple

    // 12-bit rgb, index 0 is the background
    localparam logic [11:0] PALETTE [0:15] = '{
        12'h000, 12'h225, 12'h725, 12'h085, 12'hA53, 12'h655, 12'hCCC, 12'hFFE,
        12'hF05, 12'hFA0, 12'hFF2, 12'h0E3, 12'h3AF, 12'h879, 12'hF7B, 12'hFCA
    };

endpackage

// File: draw_line.sv
// Bresenham line drawer, one pixel per cycle from (x0,y0) to (x1,y1) inclusive
// pulse start with the endpoints valid; done follows the last pixel by one cycle
`timescale 1ns/1ps

module draw_line
    import gfx_pkg::*;
(
    input  logic   clk_100m,
    input  logic   arst_n,
    input  logic   start,
    input  coord_t x0,
    input  coord_t y0,
    input  coord_t x1,
    input  coord_t y1,
    output coord_t x,
    output coord_t y,
    output logic   drawing,
    output logic   done
);

    typedef enum logic [1:0] {IDLE, INIT, DRAW} state_t;
    state_t state;

    coord_t             x_end, y_end;
    logic signed [16:0] dx, dy, err;       // dy holds minus abs(y1-y0)
    logic signed [16:0] dx_in, dy_in, err_cur;
    logic signed [17:0] e2;
    logic               x_left, y_up;      // step towards smaller x / y
    logic               last_px;

    always_comb begin
        dx_in   = (x1 >= x0) ? x1 - x0 : x0 - x1;
        dy_in   = (y1 >= y0) ? y0 - y1 : y1 - y0;
        err_cur = (state == INIT) ? dx + dy : err;  // error term primed on first pixel
        e2      = err_cur <<< 1;
        last_px = (x == x_end) && (y == y_end);
    end

    assign drawing = (state != IDLE);

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (start) state <= INIT;
                INIT, DRAW: begin
                    if (last_px) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end else begin
                        state <= DRAW;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // pixel position and error term
    always_ff @(posedge clk_100m) begin
        if (state == IDLE) begin
            if (start) begin
                x      <= x0;
                y      <= y0;
                x_end  <= x1;
                y_end  <= y1;
                dx     <= dx_in;
                dy     <= dy_in;
                x_left <= (x1 < x0);
                y_up   <= (y1 < y0);
            end
        end else if (!last_px) begin
            if (e2 >= dy) x <= x_left ? x - 1 : x + 1;
            if (e2 <= dx) y <= y_up ? y - 1 : y + 1;
            err <= err_cur + ((e2 >= dy) ? dy : 17'sd0) + ((e2 <= dx) ? dx : 17'sd0);
        end
    end

endmodule

// File: draw_triangle.sv
// triangle outline drawer, edges v0-v1, v1-v2, v2-v0 through one line drawer
// vertices must stay stable from start until done
`timescale 1ns/1ps

module draw_triangle
    import gfx_pkg::*;
(
    input  logic   clk_100m,
    input  logic   arst_n,
    input  logic   start,
    input  coord_t x0,
    input  coord_t y0,
    input  coord_t x1,
    input  coord_t y1,
    input  coord_t x2,
    input  coord_t y2,
    output coord_t x,
    output coord_t y,
    output logic   drawing,
    output logic   done
);

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;
    state_t state;

    logic [1:0] edge_id;              // current edge 0..2
    logic       line_start, line_done;
    coord_t     lx0, ly0, lx1, ly1;   // current edge endpoints

    assign done = (state == DONE);

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            edge_id    <= 2'd0;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            case (state)
                IDLE: begin
                    edge_id <= 2'd0;
                    if (start) state <= INIT;
                end
                INIT: begin
                    line_start <= 1'b1;
                    state      <= DRAW;
                end
                DRAW: begin
                    if (line_done) begin
                        if (edge_id == 2'd2) begin
                            state <= DONE;
                        end else begin
                            edge_id <= edge_id + 2'd1;
                            state   <= INIT;
                        end
                    end
                end
                default: state <= IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    // endpoint select, registered alongside line_start
    always_ff @(posedge clk_100m) begin
        if (state == INIT) begin
            case (edge_id)
                2'd0: begin
                    lx0 <= x0;
                    ly0 <= y0;
                    lx1 <= x1;
                    ly1 <= y1;
                end
                2'd1: begin
                    lx0 <= x1;
                    ly0 <= y1;
                    lx1 <= x2;
                    ly1 <= y2;
                end
                default: begin
                    lx0 <= x2;
                    ly0 <= y2;
                    lx1 <= x0;
                    ly1 <= y0;
                end
            endcase
        end
    end

    draw_line u_draw_line (
        .clk_100m (clk_100m),
        .arst_n   (arst_n),
        .start    (line_start),
        .x0       (lx0),
        .y0       (ly0),
        .x1       (lx1),
        .y1       (ly1),
        .x        (x),
        .y        (y),
        .drawing  (drawing),
        .done     (line_done)
    );

endmodule

// File: shape_sequencer.sv
// feeds the shape table to the triangle drawer, one shape after another
// starts on the first frame pulse after reset and then holds all_done
`timescale 1ns/1ps

module shape_sequencer
    import gfx_pkg::*;
(
    input  logic   clk_100m,
    input  logic   arst_n,
    input  logic   frame,
    input  logic   tri_done,
    output logic   tri_start,
    output coord_t x0,
    output coord_t y0,
    output coord_t x1,
    output coord_t y1,
    output coord_t x2,
    output coord_t y2,
    output cidx_t  cidx,
    output logic   all_done
);

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;
    state_t state;

    logic [1:0] shape_id;

    assign all_done = (state == DONE);

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            shape_id  <= 2'd0;
            tri_start <= 1'b0;
        end else begin
            tri_start <= 1'b0;
            case (state)
                IDLE: if (frame) state <= INIT;
                INIT: begin
                    tri_start <= 1'b1;
                    state     <= DRAW;
                end
                DRAW: begin
                    if (tri_done) begin
                        if (shape_id == 2'(SHAPE_CNT - 1)) begin
                            state <= DONE;
                        end else begin
                            shape_id <= shape_id + 2'd1;
                            state    <= INIT;
                        end
                    end
                end
                default: state <= DONE;  // no restart
            endcase
        end
    end

    // shape payload, held until the next INIT
    always_ff @(posedge clk_100m) begin
        if (state == INIT) begin
            x0   <= SHAPE_VX[shape_id][0];
            y0   <= SHAPE_VY[shape_id][0];
            x1   <= SHAPE_VX[shape_id][1];
            y1   <= SHAPE_VY[shape_id][1];
            x2   <= SHAPE_VX[shape_id][2];
            y2   <= SHAPE_VY[shape_id][2];
            cidx <= SHAPE_CIDX[shape_id];
        end
    end

endmodule

// File: display_timing.sv
// raster timing for the 64x36 display, active-high syncs
// all outputs are registered from the next counter values so they stay aligned
`timescale 1ns/1ps

module display_timing
    import gfx_pkg::*;
(
    input  logic   clk_100m,
    input  logic   arst_n,
    output coord_t sx,
    output coord_t sy,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output logic   frame
);

    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int VS_START = V_ACTIVE + V_FRONT;

    coord_t sx_nxt, sy_nxt;

    always_comb begin
        sx_nxt = sx + 1;
        sy_nxt = sy;
        if (sx == H_TOTAL - 1) begin
            sx_nxt = '0;
            sy_nxt = (sy == V_TOTAL - 1) ? coord_t'(0) : coord_t'(sy + 1);
        end
    end

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            hsync <= (sx_nxt >= HS_START) && (sx_nxt < HS_START + H_SYNC);
            vsync <= (sy_nxt >= VS_START) && (sy_nxt < VS_START + V_SYNC);
            de    <= (sx_nxt < H_ACTIVE) && (sy_nxt < V_ACTIVE);
            frame <= (sx_nxt == 0) && (sy_nxt == 0);  // once per frame
        end
    end

endmodule

// File: framebuffer_scanout.sv
// colour-index framebuffer, written by the drawer and scanned out in raster order
// palette lookup and sync delay both sit in one output register stage
`timescale 1ns/1ps

module framebuffer_scanout
    import gfx_pkg::*;
(
    input  logic   clk_100m,
    input  logic   we,
    input  coord_t wx,
    input  coord_t wy,
    input  cidx_t  wcidx,
    input  coord_t sx,
    input  coord_t sy,
    input  logic   de,
    input  logic   hsync,
    input  logic   vsync,
    output chan_t  red,
    output chan_t  green,
    output chan_t  blue,
    output logic   hsync_out,
    output logic   vsync_out,
    output logic   de_out
);

    cidx_t    mem [0:FB_WIDTH*FB_HEIGHT-1];
    fb_addr_t waddr, raddr;
    logic     wr_ok;

    // drop pixels that fall outside the buffer
    assign wr_ok = we && (wx >= 0) && (wx < FB_WIDTH) && (wy >= 0) && (wy < FB_HEIGHT);
    assign waddr = fb_addr_t'(wy * FB_WIDTH + wx);
    assign raddr = fb_addr_t'(sy * FB_WIDTH + sx);

    always_ff @(posedge clk_100m) begin
        if (wr_ok) mem[waddr] <= wcidx;  // read below sees the old value
    end

    always_ff @(posedge clk_100m) begin
        if (de) begin
            {red, green, blue} <= PALETTE[mem[raddr]];
        end else begin
            {red, green, blue} <= 12'h000;  // blanking
        end
        hsync_out <= hsync;
        vsync_out <= vsync;
        de_out    <= de;
    end

endmodule

// File: triangles_top.sv
// triangle renderer top, drawing and display running side by side on clk_100m
// the framebuffer joins both and drives the colour and sync outputs
`timescale 1ns/1ps

module triangles_top
    import gfx_pkg::*;
(
    input  logic  clk_100m,
    input  logic  arst_n,
    output chan_t red,
    output chan_t green,
    output chan_t blue,
    output logic  hsync,
    output logic  vsync,
    output logic  de,
    output logic  all_done
);

    coord_t sx, sy;
    logic   tim_hsync, tim_vsync, tim_de, frame;
    logic   tri_start, tri_done, drawing;
    coord_t vx0, vy0, vx1, vy1, vx2, vy2;
    coord_t px, py;  // pixel being drawn
    cidx_t  cidx;

    display_timing u_display_timing (
        .clk_100m (clk_100m),
        .arst_n   (arst_n),
        .sx       (sx),
        .sy       (sy),
        .hsync    (tim_hsync),
        .vsync    (tim_vsync),
        .de       (tim_de),
        .frame    (frame)
    );

    shape_sequencer u_shape_sequencer (
        .clk_100m  (clk_100m),
        .arst_n    (arst_n),
        .frame     (frame),
        .tri_done  (tri_done),
        .tri_start (tri_start),
        .x0        (vx0),
        .y0        (vy0),
        .x1        (vx1),
        .y1        (vy1),
        .x2        (vx2),
        .y2        (vy2),
        .cidx      (cidx),
        .all_done  (all_done)
    );

    draw_triangle u_draw_triangle (
        .clk_100m (clk_100m),
        .arst_n   (arst_n),
        .start    (tri_start),
        .x0       (vx0),
        .y0       (vy0),
        .x1       (vx1),
        .y1       (vy1),
        .x2       (vx2),
        .y2       (vy2),
        .x        (px),
        .y        (py),
        .drawing  (drawing),
        .done     (tri_done)
    );

    framebuffer_scanout u_framebuffer_scanout (
        .clk_100m  (clk_100m),
        .we        (drawing),
        .wx        (px),
        .wy        (py),
        .wcidx     (cidx),
        .sx        (sx),
        .sy        (sy),
        .de        (tim_de),
        .hsync     (tim_hsync),
        .vsync     (tim_vsync),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .hsync_out (hsync),
        .vsync_out (vsync),
        .de_out    (de)
    );

endmodule

// File: tb_clock_gen.sv
// clock and reset source for the testbench with a 100 MHz clock and a two-cycle reset
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_100m,
    output logic arst_n
);

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;  // 10 ns period
    end

    initial begin
        arst_n <= 1'b0;
        repeat (2) @(posedge clk_100m);
        arst_n <= 1'b1;  // released on the second rising edge
    end

endmodule

// File: tb_triangles.sv
// directed tests of reset, raster timing, drawing and pixels for the triangle renderer
// pixels are checked against a model framebuffer built from the shape table
`timescale 1ns/1ps

module tb_triangles
    import gfx_pkg::*;
;

    localparam int FRAME_CYCLES = 3696;
    localparam int PIXELS       = 2304;
    localparam int WATCHDOG_NS  = 8 * FRAME_CYCLES * 10;

    logic        clk_100m, arst_n;
    chan_t       red, green, blue;
    logic        hsync, vsync, de, all_done;

    int          model [0:PIXELS-1];  // colour index per pixel or -1 when undrawn
    logic [11:0] cap [0:PIXELS-1];    // captured rgb of one frame
    int          drawn_addr [$];
    int          error_cnt, ok_cnt, bad_cnt;
    int          pix_cnt, blank_bad;
    int          run_cycles, done_rise_cycle;
    logic        done_dropped;
    int unsigned seed_val;

    tb_clock_gen u_clock_gen (
        .clk_100m (clk_100m),
        .arst_n   (arst_n)
    );

    triangles_top DUT (
        .clk_100m (clk_100m),
        .arst_n   (arst_n),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .all_done (all_done)
    );

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual, input bit as_hex);
        if (as_hex) begin
            $display("FAILED %s: expected 'h%03h, actual 'h%03h", what,
                     expected[11:0], actual[11:0]);
        end else begin
            $display("FAILED %s: expected %0d, actual %0d", what, expected, actual);
        end
        error_cnt++;
    endtask

    task automatic close_test(input string name, input int errs_before);
        if (error_cnt == errs_before) begin
            $display("test %s: ok", name);
            ok_cnt++;
        end else begin
            $display("test %s: %0d errors", name, error_cnt - errs_before);
            bad_cnt++;
        end
    endtask

    // textbook Bresenham, every octant, endpoints inclusive
    task automatic paint_line(input int x0, input int y0, input int x1, input int y1,
                              input int c);
        int dx, dy, step_x, step_y, err, e2, x, y;
        bit fin;
        dx     = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy     = (y1 > y0) ? y0 - y1 : y1 - y0;  // kept negative
        step_x = (x0 < x1) ? 1 : -1;
        step_y = (y0 < y1) ? 1 : -1;
        err    = dx + dy;
        x      = x0;
        y      = y0;
        fin    = 1'b0;
        while (!fin) begin
            if (x >= 0 && x < FB_WIDTH && y >= 0 && y < FB_HEIGHT) model[y * FB_WIDTH + x] = c;
            if (x == x1 && y == y1) begin
                fin = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err = err + dy;
                    x   = x + step_x;
                end
                if (e2 <= dx) begin
                    err = err + dx;
                    y   = y + step_y;
                end
            end
        end
    endtask

    task automatic build_model();
        int a, s, e, n;
        for (a = 0; a < PIXELS; a++) model[a] = -1;
        for (s = 0; s < SHAPE_CNT; s++) begin
            for (e = 0; e < 3; e++) begin
                n = (e + 1) % 3;  // edges v0-v1, v1-v2, v2-v0
                paint_line(SHAPE_VX[s][e], SHAPE_VY[s][e], SHAPE_VX[s][n], SHAPE_VY[s][n],
                           SHAPE_CIDX[s]);
            end
        end
    endtask

    task automatic wait_vsync_rise();
        logic prev;
        prev = vsync;
        @(negedge clk_100m);
        while (!(vsync && !prev)) begin
            prev = vsync;
            @(negedge clk_100m);
        end
    endtask

    task automatic expect_outputs_low(input string when);
        if (all_done !== 1'b0) report_mismatch({"reset_state all_done ", when}, 0, all_done, 0);
        if (hsync !== 1'b0) report_mismatch({"reset_state hsync ", when}, 0, hsync, 0);
        if (vsync !== 1'b0) report_mismatch({"reset_state vsync ", when}, 0, vsync, 0);
        if (de !== 1'b0) report_mismatch({"reset_state de ", when}, 0, de, 0);
    endtask

    task automatic reset_state_test();
        int start_errs;
        start_errs = error_cnt;
        @(posedge clk_100m);
        @(negedge clk_100m);
        expect_outputs_low("during reset");
        wait (arst_n === 1'b1);
        @(negedge clk_100m);
        expect_outputs_low("after reset");
        close_test("reset_state", start_errs);
    endtask

    task automatic raster_timing_test();
        int start_errs, cycles, hs_cyc, hs_rise, de_cyc, de_rise;
        logic hs_prev, de_prev, vs_prev, rise;
        start_errs = error_cnt;
        wait_vsync_rise();
        cycles  = 0;
        hs_cyc  = 0;
        hs_rise = 0;
        de_cyc  = 0;
        de_rise = 0;
        hs_prev = hsync;
        de_prev = de;
        vs_prev = vsync;
        do begin
            @(negedge clk_100m);
            cycles++;
            if (hsync) hs_cyc++;
            if (hsync && !hs_prev) hs_rise++;
            if (de) de_cyc++;
            if (de && !de_prev) de_rise++;
            rise    = vsync && !vs_prev;
            hs_prev = hsync;
            de_prev = de;
            vs_prev = vsync;
        end while (!rise && cycles < 2 * FRAME_CYCLES);
        if (cycles != FRAME_CYCLES) report_mismatch("raster frame cycles", FRAME_CYCLES, cycles, 0);
        if (hs_cyc != 8 * 44) report_mismatch("raster hsync cycles", 8 * 44, hs_cyc, 0);
        if (hs_rise != 44) report_mismatch("raster hsync pulses", 44, hs_rise, 0);
        if (de_cyc != 64 * 36) report_mismatch("raster de cycles", 64 * 36, de_cyc, 0);
        if (de_rise != 36) report_mismatch("raster active lines", 36, de_rise, 0);
        close_test("raster_timing", start_errs);
    endtask

    task automatic drawing_done_test();
        int start_errs;
        start_errs = error_cnt;
        while (done_rise_cycle < 0 && run_cycles <= 2 * FRAME_CYCLES) @(negedge clk_100m);
        if (done_rise_cycle < 0 || done_rise_cycle > 2 * FRAME_CYCLES) begin
            $display("FAILED drawing_done: all_done did not rise within two frames of reset");
            error_cnt++;
        end else if (done_dropped) begin
            $display("FAILED drawing_done: all_done went low again after rising");
            error_cnt++;
        end
        close_test("drawing_done", start_errs);
    endtask

    // captures one whole frame between vsync rises with de cycles in raster order
    task automatic capture_frame();
        int idx;
        logic vs_prev, rise;
        idx       = 0;
        blank_bad = 0;
        wait_vsync_rise();
        vs_prev = vsync;
        do begin
            @(negedge clk_100m);
            if (de) begin
                if (idx < PIXELS) cap[idx] = {red, green, blue};
                idx++;
            end else if ({red, green, blue} !== 12'h000) begin
                blank_bad++;
            end
            rise    = vsync && !vs_prev;
            vs_prev = vsync;
        end while (!rise);
        pix_cnt = idx;
    endtask

    task automatic pixel_contents_test();
        int start_errs, a, s, v;
        start_errs = error_cnt;
        capture_frame();
        if (pix_cnt != PIXELS) report_mismatch("pixel_contents de pixels", PIXELS, pix_cnt, 0);
        for (a = 0; a < PIXELS; a++) begin
            if (model[a] >= 0 && cap[a] !== PALETTE[model[a]]) begin
                report_mismatch($sformatf("pixel_contents (%0d,%0d)", a % FB_WIDTH, a / FB_WIDTH),
                                PALETTE[model[a]], cap[a], 1);
            end
        end
        for (s = 0; s < SHAPE_CNT; s++) begin
            for (v = 0; v < 3; v++) begin
                a = SHAPE_VY[s][v] * FB_WIDTH + SHAPE_VX[s][v];
                if (cap[a] !== PALETTE[model[a]]) begin
                    report_mismatch($sformatf("pixel_contents vertex %0d of shape %0d", v, s),
                                    PALETTE[model[a]], cap[a], 1);
                end
            end
        end
        close_test("pixel_contents", start_errs);
    endtask

    task automatic blanking_test();
        int start_errs, n, a;
        start_errs = error_cnt;
        for (a = 0; a < PIXELS; a++) begin
            if (model[a] >= 0) drawn_addr.push_back(a);
        end
        for (n = 0; n < 40; n++) begin
            a = drawn_addr[$urandom % drawn_addr.size()];  // random known pixel
            if (cap[a] !== PALETTE[model[a]]) begin
                report_mismatch($sformatf("background sample (%0d,%0d)", a % FB_WIDTH,
                                a / FB_WIDTH), PALETTE[model[a]], cap[a], 1);
            end
        end
        if (blank_bad != 0) report_mismatch("blanking cycles with colour", 0, blank_bad, 0);
        close_test("background_blanking", start_errs);
    endtask

    // tracks when all_done first rises and whether it ever falls again
    initial begin
        run_cycles      = 0;
        done_rise_cycle = -1;
        done_dropped    = 1'b0;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge clk_100m);
            run_cycles++;
            if (all_done === 1'b1 && done_rise_cycle < 0) done_rise_cycle = run_cycles;
            if (all_done !== 1'b1 && done_rise_cycle >= 0) done_dropped = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: tests did not finish within 8 frames");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        error_cnt = 0;
        ok_cnt    = 0;
        bad_cnt   = 0;
        seed_val  = $urandom(32'h7976_fb09);
        build_model();
        reset_state_test();
        raster_timing_test();
        drawing_done_test();
        pixel_contents_test();
        blanking_test();
        $display("%0d tests ok, %0d tests failed, %0d check errors", ok_cnt, bad_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
gfx_pkg.sv
draw_line.sv
draw_triangle.sv
shape_sequencer.sv
display_timing.sv
framebuffer_scanout.sv
triangles_top.sv
tb_clock_gen.sv
tb_triangles.sv
